//--- debug_cmd_pkg.sv
package debug_cmd_pkg;

    typedef logic [7:0] byte_t;                     // One protocol byte.

    typedef struct packed {
        logic  valid;                               // One-cycle strobe, no ready.
        byte_t data;
    } rx_byte_t;

    typedef struct packed {
        logic  valid;                               // Held until ready.
        byte_t data;
    } tx_byte_t;

    // A received byte seen either as a whole opcode or split into fields.
    typedef union packed {
        byte_t opcode;
        struct packed {
            logic [4:0] upper;
            logic       step;                       // High selects single step.
            logic [1:0] low;
        } fields;
    } cmd_byte_u;

    localparam byte_t CMD_LOAD        = 8'h00;
    localparam byte_t CMD_RUN         = 8'h03;
    localparam byte_t CMD_STEP        = 8'h07;
    localparam byte_t REPLY_LOAD_ACK  = 8'h01;
    localparam byte_t REPLY_DUMP_DONE = 8'h0B;

    typedef enum logic [1:0] {
        TX_SRC_ACK,                                 // Load acknowledge.
        TX_SRC_REG,                                 // Register byte.
        TX_SRC_DONE                                 // End of dump.
    } tx_src_e;

endpackage

//--- debug_cpu_pkg.sv
package debug_cpu_pkg;

    localparam int WORD_WIDTH      = 32;            // Instruction and register width.
    localparam int BYTES_PER_WORD  = 4;
    localparam int PROG_ADDR_WIDTH = 10;            // Program memory depth 1024 words.

    typedef logic [WORD_WIDTH-1:0] word_t;

    // HALT instruction of the core.
    localparam word_t HALT_WORD = '1;

    //////////////////////////////////////////////////////////////////////
    // Program memory write port
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic                       strobe;         // One write per high cycle.
        logic [PROG_ADDR_WIDTH-1:0] addr;
        word_t                      data;
    } prog_write_t;

    //////////////////////////////////////////////////////////////////////
    // Core run control
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic enable;                               // Stage enable.
        logic step_mode;                            // Set in single-step runs.
    } run_ctrl_t;

endpackage

//--- debug_index_counter.sv
`timescale 1ns/1ps

module debug_index_counter #(
    parameter int NUM_REGS = 32
) (
    input  logic                                      i_clock,
    input  logic                                      i_reset,
    input  logic                                      i_clear,
    input  logic                                      i_advance,
    output logic [1:0]                                o_byte_idx,
    output logic [debug_cpu_pkg::PROG_ADDR_WIDTH-1:0] o_item_idx,
    output logic                                      o_byte_last,
    output logic                                      o_item_last
);

    localparam int ITEM_W = debug_cpu_pkg::PROG_ADDR_WIDTH;
    localparam logic [1:0] LAST_BYTE = 2'(debug_cpu_pkg::BYTES_PER_WORD - 1);
    localparam logic [ITEM_W-1:0] LAST_ITEM = ITEM_W'(NUM_REGS - 1);

    logic [1:0]        byte_q;
    logic [ITEM_W-1:0] item_q;

    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            byte_q <= '0;
            item_q <= '0;
        end else if (i_clear) begin
            byte_q <= '0;
            item_q <= '0;
        end else if (i_advance) begin
            byte_q <= byte_q + 2'd1;                // Wraps after the fourth byte.
            if (o_byte_last) begin
                item_q <= item_q + 1'b1;            // Next word or register.
            end
        end
    end

    assign o_byte_idx  = byte_q;
    assign o_item_idx  = item_q;
    assign o_byte_last = (byte_q == LAST_BYTE);
    assign o_item_last = (item_q == LAST_ITEM);

endmodule

//--- program_loader.sv
`timescale 1ns/1ps

module program_loader (
    input  logic                                      i_clock,
    input  logic                                      i_reset,
    input  logic                                      i_load_en,
    input  debug_cmd_pkg::rx_byte_t                   i_rx,
    input  logic                                      i_byte_last,
    input  logic [debug_cpu_pkg::PROG_ADDR_WIDTH-1:0] i_item_idx,
    output debug_cpu_pkg::prog_write_t                o_prog,
    output logic                                      o_halt_written
);

    localparam int WORD_W = debug_cpu_pkg::WORD_WIDTH;
    localparam int BYTE_W = $bits(debug_cmd_pkg::byte_t);

    debug_cpu_pkg::word_t                      word_q;
    debug_cpu_pkg::word_t                      word_next;
    logic                                      take_byte;
    logic                                      strobe_q;
    logic [debug_cpu_pkg::PROG_ADDR_WIDTH-1:0] addr_q;
    debug_cpu_pkg::word_t                      data_q;

    assign take_byte = i_load_en && i_rx.valid;
    assign word_next = {word_q[WORD_W-BYTE_W-1:0], i_rx.data}; // First byte ends up on top.

    always_ff @(posedge i_clock) begin
        if (take_byte) begin
            word_q <= word_next;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Write register towards program memory
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            strobe_q <= 1'b0;
        end else begin
            strobe_q <= take_byte && i_byte_last;   // Single-cycle write.
        end
    end

    always_ff @(posedge i_clock) begin
        if (take_byte && i_byte_last) begin
            addr_q <= i_item_idx;                   // Words counted so far.
            data_q <= word_next;
        end
    end

    assign o_prog = '{strobe: strobe_q, addr: addr_q, data: data_q};

    // Loading stops once the HALT word is in memory.
    assign o_halt_written = strobe_q && (data_q == debug_cpu_pkg::HALT_WORD);

endmodule

//--- dump_serializer.sv
`timescale 1ns/1ps

module dump_serializer (
    input  logic                   i_clock,
    input  logic                   i_reset,
    input  logic                   i_tx_req,
    input  debug_cmd_pkg::tx_src_e i_tx_src,
    input  logic [1:0]             i_byte_idx,
    input  debug_cpu_pkg::word_t   i_reg_data,
    output debug_cmd_pkg::tx_byte_t o_tx,
    input  logic                   i_tx_ready,
    output logic                   o_slot_free
);

    localparam logic [1:0] TOP_BYTE = 2'(debug_cpu_pkg::BYTES_PER_WORD - 1);

    debug_cmd_pkg::byte_t [debug_cpu_pkg::BYTES_PER_WORD-1:0] reg_bytes;
    debug_cmd_pkg::byte_t                                     next_byte;
    logic                                                     load;
    logic                                                     tx_valid;
    debug_cmd_pkg::byte_t                                     tx_data;

    assign reg_bytes = i_reg_data;

    always_comb begin
        case (i_tx_src)
            debug_cmd_pkg::TX_SRC_ACK:  next_byte = debug_cmd_pkg::REPLY_LOAD_ACK;
            debug_cmd_pkg::TX_SRC_DONE: next_byte = debug_cmd_pkg::REPLY_DUMP_DONE;
            default:                    next_byte = reg_bytes[TOP_BYTE - i_byte_idx]; // Byte 0 is MSB.
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // One-entry transmit register
    //////////////////////////////////////////////////////////////////////

    // Free when empty or when the held byte leaves this cycle.
    assign o_slot_free = !tx_valid || i_tx_ready;
    assign load        = i_tx_req && o_slot_free;

    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            tx_valid <= 1'b0;
        end else if (load) begin
            tx_valid <= 1'b1;
        end else if (i_tx_ready) begin
            tx_valid <= 1'b0;                       // Transferred, nothing new.
        end
    end

    always_ff @(posedge i_clock) begin
        if (load) begin
            tx_data <= next_byte;                   // Held while ready is low.
        end
    end

    assign o_tx = '{valid: tx_valid, data: tx_data};

endmodule

//--- debug_fsm.sv
`timescale 1ns/1ps

module debug_fsm #(
    parameter int NUM_REGS = 32
) (
    input  logic                     i_clock,
    input  logic                     i_reset,
    input  debug_cmd_pkg::rx_byte_t  i_rx,
    input  logic                     i_halt,
    input  logic                     i_item_last,
    input  logic                     i_byte_last,
    input  logic                     i_halt_written,
    input  logic                     i_slot_free,
    output logic                     o_cnt_clear,
    output logic                     o_cnt_advance,
    output logic                     o_load_en,
    output logic                     o_tx_req,
    output debug_cmd_pkg::tx_src_e   o_tx_src,
    output debug_cpu_pkg::run_ctrl_t o_run
);

    // Register index shares the 10-bit item counter with program addresses.
    if (NUM_REGS < 1 || NUM_REGS > (1 << debug_cpu_pkg::PROG_ADDR_WIDTH)) begin : g_num_regs_check
        $error("NUM_REGS does not fit the item index");
    end

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOAD,
        ST_WAIT_START,
        ST_RUN,
        ST_DUMP,
        ST_DONE
    } state_e;

    state_e                  state_q;
    state_e                  state_d;
    debug_cmd_pkg::cmd_byte_u rx_cmd;
    logic                    is_load;
    logic                    is_start;
    logic                    step_q;
    logic                    done_sent_q;

    // Decode every received byte both as opcode and as fields.
    assign rx_cmd.opcode = i_rx.data;
    assign is_load  = i_rx.valid && (rx_cmd.opcode == debug_cmd_pkg::CMD_LOAD);
    assign is_start = i_rx.valid && ((rx_cmd.opcode == debug_cmd_pkg::CMD_RUN) ||
                                     (rx_cmd.opcode == debug_cmd_pkg::CMD_STEP));

    //////////////////////////////////////////////////////////////////////
    // Next state and controls
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        state_d       = state_q;
        o_cnt_advance = 1'b0;
        o_tx_req      = 1'b0;
        o_tx_src      = debug_cmd_pkg::TX_SRC_REG;
        case (state_q)
            ST_IDLE: begin
                if (is_load) begin
                    o_tx_req = 1'b1;
                    o_tx_src = debug_cmd_pkg::TX_SRC_ACK;
                    state_d  = ST_LOAD;
                end
            end
            ST_LOAD: begin
                o_cnt_advance = i_rx.valid;         // Every byte is program data.
                if (i_halt_written) begin
                    state_d = ST_WAIT_START;
                end
            end
            ST_WAIT_START: begin
                if (is_start && i_slot_free) begin  // No run while a reply is pending.
                    state_d = ST_RUN;
                end
            end
            ST_RUN: begin
                if (step_q || i_halt) begin
                    state_d = ST_DUMP;              // A step lasts one cycle.
                end
            end
            ST_DUMP: begin
                o_tx_req = 1'b1;
                if (i_slot_free) begin
                    o_cnt_advance = 1'b1;
                    if (i_item_last && i_byte_last) begin
                        state_d = ST_DONE;
                    end
                end
            end
            ST_DONE: begin
                if (!done_sent_q) begin
                    o_tx_req = 1'b1;
                    o_tx_src = debug_cmd_pkg::TX_SRC_DONE;
                end else if (i_slot_free) begin
                    // Done byte is out, a plain step may go on.
                    state_d = (!step_q || i_halt) ? ST_IDLE : ST_WAIT_START;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            state_q     <= ST_IDLE;
            step_q      <= 1'b0;
            done_sent_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            done_sent_q <= (state_q == ST_DONE) && (state_d == ST_DONE) &&
                           (done_sent_q || i_slot_free);    // Done byte taken.
            if (state_q == ST_WAIT_START && state_d == ST_RUN) begin
                step_q <= rx_cmd.fields.step;       // Bit 2 of the start byte.
            end
        end
    end

    assign o_cnt_clear = (state_q == ST_IDLE) || (state_q == ST_WAIT_START) ||
                         (state_q == ST_RUN);
    assign o_load_en   = (state_q == ST_LOAD);
    assign o_run       = '{enable: (state_q == ST_RUN), step_mode: step_q};

endmodule

//--- debug_unit_top.sv
`timescale 1ns/1ps

module debug_unit_top #(
    parameter int NUM_REGS = 32
) (
    input  logic                                                 i_clock,
    input  logic                                                 i_reset,
    input  debug_cmd_pkg::rx_byte_t                              i_rx,
    output debug_cmd_pkg::tx_byte_t                              o_tx,
    input  logic                                                 i_tx_ready,
    output debug_cpu_pkg::prog_write_t                           o_prog,
    output logic [((NUM_REGS > 1) ? $clog2(NUM_REGS) : 1)-1:0]   o_reg_addr,
    input  debug_cpu_pkg::word_t                                 i_reg_data,
    output debug_cpu_pkg::run_ctrl_t                             o_run,
    input  logic                                                 i_halt
);

    localparam int REG_ADDR_WIDTH = (NUM_REGS > 1) ? $clog2(NUM_REGS) : 1;

    logic                                      cnt_clear;
    logic                                      cnt_advance;
    logic                                      load_en;
    logic                                      tx_req;
    debug_cmd_pkg::tx_src_e                    tx_src;
    logic [1:0]                                byte_idx;
    logic [debug_cpu_pkg::PROG_ADDR_WIDTH-1:0] item_idx;
    logic                                      byte_last;
    logic                                      item_last;
    logic                                      halt_written;
    logic                                      slot_free;

    //////////////////////////////////////////////////////////////////////
    // Control and counting
    //////////////////////////////////////////////////////////////////////

    debug_fsm #(.NUM_REGS(NUM_REGS)) u_fsm (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_rx          (i_rx),
        .i_halt        (i_halt),
        .i_item_last   (item_last),
        .i_byte_last   (byte_last),
        .i_halt_written(halt_written),
        .i_slot_free   (slot_free),
        .o_cnt_clear   (cnt_clear),
        .o_cnt_advance (cnt_advance),
        .o_load_en     (load_en),
        .o_tx_req      (tx_req),
        .o_tx_src      (tx_src),
        .o_run         (o_run)
    );

    debug_index_counter #(.NUM_REGS(NUM_REGS)) u_counter (
        .i_clock    (i_clock),
        .i_reset    (i_reset),
        .i_clear    (cnt_clear),
        .i_advance  (cnt_advance),
        .o_byte_idx (byte_idx),
        .o_item_idx (item_idx),
        .o_byte_last(byte_last),
        .o_item_last(item_last)
    );

    // Register file is read at the current dump index.
    assign o_reg_addr = item_idx[REG_ADDR_WIDTH-1:0];

    //////////////////////////////////////////////////////////////////////
    // Data paths
    //////////////////////////////////////////////////////////////////////

    program_loader u_loader (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_load_en     (load_en),
        .i_rx          (i_rx),
        .i_byte_last   (byte_last),
        .i_item_idx    (item_idx),
        .o_prog        (o_prog),
        .o_halt_written(halt_written)
    );

    dump_serializer u_serializer (
        .i_clock    (i_clock),
        .i_reset    (i_reset),
        .i_tx_req   (tx_req),
        .i_tx_src   (tx_src),
        .i_byte_idx (byte_idx),
        .i_reg_data (i_reg_data),
        .o_tx       (o_tx),
        .i_tx_ready (i_tx_ready),
        .o_slot_free(slot_free)
    );

endmodule

//--- debug_unit_properties.sv
`timescale 1ns/1ps

module debug_unit_properties (
    input logic                       i_clock,
    input logic                       i_reset,
    input logic                       i_load_en,
    input debug_cmd_pkg::tx_byte_t    o_tx,
    input logic                       i_tx_ready,
    input debug_cpu_pkg::prog_write_t o_prog,
    input debug_cpu_pkg::run_ctrl_t   o_run
);

    int                                        failures = 0;
    logic [debug_cpu_pkg::PROG_ADDR_WIDTH-1:0] addr_expect;

    // Address the next program write must use.
    always_ff @(posedge i_clock) begin
        if (!i_reset || !i_load_en) begin
            addr_expect <= '0;
        end else if (o_prog.strobe) begin
            addr_expect <= o_prog.addr + 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Transmit handshake
    //////////////////////////////////////////////////////////////////////

    a_tx_stable: assert property (@(posedge i_clock) disable iff (!i_reset)
        o_tx.valid && !i_tx_ready |=> $stable(o_tx.data))
        else begin
            failures++;
            $error("tx data changed while stalled");
        end

    a_tx_keep: assert property (@(posedge i_clock) disable iff (!i_reset)
        o_tx.valid && !i_tx_ready |=> o_tx.valid)
        else begin
            failures++;
            $error("tx valid dropped without a transfer");
        end

    //////////////////////////////////////////////////////////////////////
    // Program writes and run control
    //////////////////////////////////////////////////////////////////////

    a_prog_order: assert property (@(posedge i_clock) disable iff (!i_reset)
        o_prog.strobe |-> o_prog.addr == addr_expect)
        else begin
            failures++;
            $error("program write address out of order");
        end

    a_run_quiet: assert property (@(posedge i_clock) disable iff (!i_reset)
        !(o_run.enable && o_tx.valid))
        else begin
            failures++;
            $error("core enabled while a reply is pending");
        end

    a_step_pulse: assert property (@(posedge i_clock) disable iff (!i_reset)
        o_run.enable && o_run.step_mode |=> !o_run.enable)
        else begin
            failures++;
            $error("step enable longer than one cycle");
        end

endmodule

bind debug_unit_top debug_unit_properties u_props (
    .i_clock   (i_clock),
    .i_reset   (i_reset),
    .i_load_en (load_en),
    .o_tx      (o_tx),
    .i_tx_ready(i_tx_ready),
    .o_prog    (o_prog),
    .o_run     (o_run)
);

//--- tb_debug_unit.sv
`timescale 1ns/1ps

module tb_debug_unit;

    localparam int NUM_REGS   = 32;
    localparam int REG_ADDR_W = $clog2(NUM_REGS);
    localparam int PROG_LEN   = 4;
    localparam int HALT_AFTER = 6;                  // Core cycles before HALT.
    localparam int WAIT_LIMIT = 2000;

    logic                       i_clock    = 1'b0;
    logic                       i_reset;
    debug_cmd_pkg::rx_byte_t    i_rx;
    debug_cmd_pkg::tx_byte_t    o_tx;
    logic                       i_tx_ready = 1'b1;
    debug_cpu_pkg::prog_write_t o_prog;
    logic [REG_ADDR_W-1:0]      o_reg_addr;
    debug_cpu_pkg::word_t       i_reg_data;
    debug_cpu_pkg::run_ctrl_t   o_run;
    logic                       i_halt     = 1'b0;

    integer                     seed       = 32'h452c;
    int                         rnd;
    logic                       bp_on      = 1'b0;
    int                         run_cnt    = 0;
    logic                       halt_seen  = 1'b0;
    logic                       step_expect = 1'b0;
    int                         en_cycles  = 0;
    int                         errors     = 0;
    int                         timeouts   = 0;
    debug_cpu_pkg::word_t       reg_file [NUM_REGS];
    debug_cpu_pkg::word_t       program_words [PROG_LEN];
    debug_cmd_pkg::byte_t       tx_q [$];   // Every byte that left on o_tx.
    debug_cpu_pkg::prog_write_t wr_q [$];   // Every program memory write.

    debug_unit_top #(.NUM_REGS(NUM_REGS)) dut (
        .i_clock   (i_clock),
        .i_reset   (i_reset),
        .i_rx      (i_rx),
        .o_tx      (o_tx),
        .i_tx_ready(i_tx_ready),
        .o_prog    (o_prog),
        .o_reg_addr(o_reg_addr),
        .i_reg_data(i_reg_data),
        .o_run     (o_run),
        .i_halt    (i_halt)
    );

    always #4 i_clock = ~i_clock;                   // 8 ns period.

    //////////////////////////////////////////////////////////////////////
    // Register file, core and host models
    //////////////////////////////////////////////////////////////////////

    assign i_reg_data = reg_file[o_reg_addr];       // Combinational read.

    always @(posedge i_clock) begin
        if (!o_run.enable) begin
            run_cnt <= 0;
            i_halt  <= 1'b0;
        end else begin
            run_cnt <= run_cnt + 1;
            if (!o_run.step_mode && run_cnt == HALT_AFTER - 1) begin
                i_halt <= 1'b1;                     // Program reached HALT.
            end
        end
    end

    always @(posedge i_clock) begin
        rnd = $random(seed);
        i_tx_ready <= !bp_on || rnd[0];             // Random stalls when enabled.
    end

    always @(posedge i_clock) begin
        if (i_reset) begin
            if (o_tx.valid && i_tx_ready) begin
                tx_q.push_back(o_tx.data);
            end
            if (o_prog.strobe) begin
                wr_q.push_back(o_prog);
            end
            if (o_run.enable) begin
                en_cycles++;
                assert (o_run.step_mode == step_expect)
                    else report_mismatch("run mode differs from the start byte");
            end
            if (halt_seen) begin
                assert (!o_run.enable) else report_mismatch("enable still high after halt");
            end
            halt_seen <= o_run.enable && i_halt;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Tasks
    //////////////////////////////////////////////////////////////////////

    task automatic report_mismatch(input string msg);
        errors++;
        $display("Mismatch at %0t ns: %s", $time, msg);
    endtask

    task automatic send_byte(input debug_cmd_pkg::byte_t b);
        @(posedge i_clock);
        i_rx <= '{valid: 1'b1, data: b};
        @(posedge i_clock);
        i_rx <= '{valid: 1'b0, data: 8'h00};
    endtask

    task automatic wait_count(input bit on_tx, input int target, input string what);
        int cycles;
        cycles = 0;
        while ((on_tx ? tx_q.size() : wr_q.size()) < target && cycles < WAIT_LIMIT) begin
            @(posedge i_clock);
            cycles++;
        end
        if ((on_tx ? tx_q.size() : wr_q.size()) < target) begin
            timeouts++;
            $display("Timeout at %0t ns: no %s within %0d cycles", $time, what, WAIT_LIMIT);
        end
    endtask

    task automatic check_quiet(input string when);
        assert (!o_tx.valid && !o_prog.strobe && !o_run.enable)
            else report_mismatch({"outputs active ", when});
    endtask

    task automatic apply_reset();
        i_reset <= 1'b0;
        i_rx    <= '0;
        @(posedge i_clock);
        repeat (9) begin
            @(posedge i_clock);
            check_quiet("during reset");
        end
        i_reset <= 1'b1;
        repeat (2) begin
            @(posedge i_clock);
            check_quiet("after reset");
        end
    endtask

    task automatic load_program();
        int tx_base;
        int wr_base;
        if (timeouts != 0) begin
            return;
        end
        tx_base = tx_q.size();
        wr_base = wr_q.size();
        send_byte(debug_cmd_pkg::CMD_LOAD);
        for (int w = 0; w < PROG_LEN; w++) begin
            for (int b = 0; b < 4; b++) begin
                send_byte(program_words[w][31-8*b -: 8]);  // Most significant first.
            end
        end
        wait_count(1'b0, wr_base + PROG_LEN, "program write");
        wait_count(1'b1, tx_base + 1, "load acknowledge");
        if (timeouts != 0) begin
            return;
        end
        repeat (4) @(posedge i_clock);
        assert (tx_q[tx_base] == debug_cmd_pkg::REPLY_LOAD_ACK)
            else report_mismatch($sformatf("reply %02h after load", tx_q[tx_base]));
        assert (wr_q.size() == wr_base + PROG_LEN)
            else report_mismatch($sformatf("%0d program writes", wr_q.size() - wr_base));
        for (int w = 0; w < PROG_LEN; w++) begin
            assert (int'(wr_q[wr_base + w].addr) == w &&
                    wr_q[wr_base + w].data == program_words[w])
                else report_mismatch($sformatf("write %0d went to %0d with %08h", w,
                                     wr_q[wr_base + w].addr, wr_q[wr_base + w].data));
        end
        assert (wr_q[wr_q.size() - 1].data == debug_cpu_pkg::HALT_WORD)
            else report_mismatch("last program write is not HALT");
    endtask

    task automatic run_and_dump(input debug_cmd_pkg::byte_t start, input int enable_cycles);
        int tx_base;
        int en_base;
        int k;
        if (timeouts != 0) begin
            return;
        end
        tx_base     = tx_q.size();
        en_base     = en_cycles;
        step_expect = (start == debug_cmd_pkg::CMD_STEP);   // 0x07 asks for one step.
        send_byte(start);
        wait_count(1'b1, tx_base + 4 * NUM_REGS + 1, "end of register dump");
        if (timeouts != 0) begin
            return;
        end
        assert (en_cycles - en_base == enable_cycles)
            else report_mismatch($sformatf("enable high %0d cycles, expected %0d",
                                 en_cycles - en_base, enable_cycles));
        for (int r = 0; r < NUM_REGS; r++) begin
            for (int b = 0; b < 4; b++) begin
                k = tx_base + 4 * r + b;
                assert (tx_q[k] == reg_file[r][31-8*b -: 8])
                    else report_mismatch($sformatf("register %0d byte %0d is %02h", r, b,
                                         tx_q[k]));
            end
        end
        assert (tx_q[tx_base + 4 * NUM_REGS] == debug_cmd_pkg::REPLY_DUMP_DONE)
            else report_mismatch("dump not closed by the done byte");
        repeat (4) @(posedge i_clock);
    endtask

    task automatic finish_run();
        $display("Errors: %0d mismatches, %0d timeouts, %0d assertion failures",
                 errors, timeouts, dut.u_props.failures);
        if (errors == 0 && timeouts == 0 && dut.u_props.failures == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        for (int r = 0; r < NUM_REGS; r++) begin
            reg_file[r] = $random(seed);
        end
        program_words[0] = 32'h2001_0005;
        program_words[1] = 32'h2002_000a;
        program_words[2] = 32'h0022_1820;
        program_words[3] = debug_cpu_pkg::HALT_WORD;
        apply_reset();
        load_program();
        run_and_dump(debug_cmd_pkg::CMD_RUN, HALT_AFTER + 1);
        bp_on <= 1'b1;                              // Host stalls from here on.
        load_program();
        run_and_dump(debug_cmd_pkg::CMD_RUN, HALT_AFTER + 1);
        load_program();
        run_and_dump(debug_cmd_pkg::CMD_STEP, 1);
        run_and_dump(debug_cmd_pkg::CMD_STEP, 1);   // No reload between steps.
        finish_run();
    end

endmodule

//--- debug_unit_top.f
debug_cmd_pkg.sv
debug_cpu_pkg.sv
debug_index_counter.sv
program_loader.sv
dump_serializer.sv
debug_fsm.sv
debug_unit_top.sv
debug_unit_properties.sv
tb_debug_unit.sv

//--- Makefile
# Verilator build and run for the debug unit testbench.

VERILATOR ?= verilator
TOP       ?= tb_debug_unit
FILELIST  ?= debug_unit_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= sim failed
PASS_MSG  ?= sim passed
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

SOURCES   := $(shell cat $(FILELIST))
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended without result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
